//--- smc_pkg.sv
// Shared definitions for the static memory controller
// Bus widths and byte lane count
// Timing counter width
// AHB-Lite transfer, size and response codes
// External cycle state encoding

package smc_pkg;

  //--------------------------------------------------------------------------
  // Widths
  //--------------------------------------------------------------------------
  parameter int ADDR_W    = 32;   // AHB and memory address
  parameter int DATA_W    = 32;   // Data bus
  parameter int NUM_LANES = 4;    // Byte lanes on the data bus
  parameter int CNT_W     = 8;    // Bounds every timing parameter

  //--------------------------------------------------------------------------
  // AHB-Lite codes
  //--------------------------------------------------------------------------
  parameter logic [1:0] HTRANS_IDLE   = 2'b00;
  parameter logic [1:0] HTRANS_BUSY   = 2'b01;
  parameter logic [1:0] HTRANS_NONSEQ = 2'b10;
  parameter logic [1:0] HTRANS_SEQ    = 2'b11;

  parameter logic [2:0] HSIZE_BYTE = 3'b000;
  parameter logic [2:0] HSIZE_HALF = 3'b001;
  parameter logic [2:0] HSIZE_WORD = 3'b010;   // Larger sizes handled as word

  parameter logic [1:0] HRESP_OKAY = 2'b00;    // Only response ever given

  // External cycle phases
  typedef enum logic [1:0] {
    ST_IDLE   = 2'b00,   // Waiting for an accepted transfer
    ST_CSLE   = 2'b01,   // Chip select lead time
    ST_STROBE = 2'b10,   // Strobe active plus wait states
    ST_CSTE   = 2'b11    // Chip select trail, bus float
  } smc_state_t;

endpackage

//--- smc_ahb_if.sv
// AHB-Lite slave side of the memory controller
// Transfer qualification and acceptance
// Direction register and write data capture
// Read data holding register, ready and response

`timescale 1ns/10ps

module smc_ahb_if (
  input  logic                       hclk,
  input  logic                       rst_n,
  input  logic                       hsel,
  input  logic [1:0]                 htrans,
  input  logic                       hwrite,
  input  logic [smc_pkg::DATA_W-1:0] hwdata,
  input  logic                       hready,
  input  logic [smc_pkg::DATA_W-1:0] data_smc,     // Read data from memory
  input  smc_pkg::smc_state_t        state,
  input  logic                       latch_data,   // Last strobe cycle of a read
  output logic                       new_access,
  output logic                       access_write,
  output logic [smc_pkg::DATA_W-1:0] smc_data,     // Write data to memory
  output logic [smc_pkg::DATA_W-1:0] smc_hrdata,
  output logic                       smc_hready,
  output logic [1:0]                 smc_hresp
);

  logic idle;          // No external cycle running
  logic xfer_valid;    // NONSEQ or SEQ on the bus
  logic write_q;       // Direction of the last accepted transfer
  logic wdata_phase;   // First data phase cycle of a write

  //--------------------------------------------------------------------------
  // Acceptance
  //--------------------------------------------------------------------------
  assign idle       = (state == smc_pkg::ST_IDLE);
  assign xfer_valid = (htrans == smc_pkg::HTRANS_NONSEQ) ||
                      (htrans == smc_pkg::HTRANS_SEQ);

  // BUSY and IDLE are ignored, as is anything while a cycle runs
  assign new_access = hsel && hready && xfer_valid && idle;

  // Bypass during acceptance so the strobe registers see the
  // direction at the accepting edge
  assign access_write = new_access ? hwrite : write_q;

  always_ff @(posedge hclk or negedge rst_n) begin
    if (!rst_n) begin
      write_q     <= 1'b0;
      wdata_phase <= 1'b0;
    end else begin
      if (new_access) begin
        write_q <= hwrite;
      end
      wdata_phase <= new_access && hwrite;   // One cycle pulse
    end
  end

  //--------------------------------------------------------------------------
  // Data paths
  //--------------------------------------------------------------------------
  // hwdata is valid in the first data phase cycle, before any strobe
  always_ff @(posedge hclk) begin
    if (wdata_phase) begin
      smc_data <= hwdata;
    end
  end

  // Held until the next read completes
  always_ff @(posedge hclk) begin
    if (latch_data) begin
      smc_hrdata <= data_smc;
    end
  end

  //--------------------------------------------------------------------------
  // Handshake
  //--------------------------------------------------------------------------
  assign smc_hready = idle;                  // Data phase ends on return to idle
  assign smc_hresp  = smc_pkg::HRESP_OKAY;   // No error responses

endmodule

//--- smc_state.sv
// External cycle state machine
// Idle, chip select lead, strobe with wait states, chip select trail
// Single down-counter paces every phase
// Read data latch pulse in the last strobe cycle

`timescale 1ns/10ps

module smc_state #(
  parameter int CSLE_CYCLES = 1,
  parameter int WS_CYCLES   = 2,
  parameter int CSTE_CYCLES = 1
) (
  input  logic                hclk,
  input  logic                rst_n,
  input  logic                new_access,
  input  logic                access_write,
  output smc_pkg::smc_state_t state,
  output smc_pkg::smc_state_t next_state,
  output logic                latch_data
);

  localparam int CW = smc_pkg::CNT_W;

  // Counter reload values, the counter runs down to zero in each phase
  localparam logic [CW-1:0] CSLE_LOAD = CW'(CSLE_CYCLES - 1);
  localparam logic [CW-1:0] WS_LOAD   = CW'(WS_CYCLES);
  localparam logic [CW-1:0] CSTE_LOAD = CW'(CSTE_CYCLES - 1);
  localparam bit            SKIP_CSTE = (CSTE_CYCLES == 0);

  logic [CW-1:0] cnt;        // Cycles left in the current phase
  logic [CW-1:0] cnt_next;
  logic          cnt_zero;   // Last cycle of the phase

  assign cnt_zero = (cnt == '0);

  //--------------------------------------------------------------------------
  // Next state and counter
  //--------------------------------------------------------------------------
  always_comb begin
    next_state = state;
    cnt_next   = cnt;
    case (state)
      smc_pkg::ST_IDLE: begin
        if (new_access) begin
          next_state = smc_pkg::ST_CSLE;
          cnt_next   = CSLE_LOAD;
        end
      end
      smc_pkg::ST_CSLE: begin
        if (cnt_zero) begin
          next_state = smc_pkg::ST_STROBE;
          cnt_next   = WS_LOAD;           // WS wait states plus one
        end else begin
          cnt_next = cnt - 1'b1;
        end
      end
      smc_pkg::ST_STROBE: begin
        if (cnt_zero) begin
          if (SKIP_CSTE) begin
            next_state = smc_pkg::ST_IDLE;   // No bus float time
          end else begin
            next_state = smc_pkg::ST_CSTE;
            cnt_next   = CSTE_LOAD;
          end
        end else begin
          cnt_next = cnt - 1'b1;
        end
      end
      smc_pkg::ST_CSTE: begin
        if (cnt_zero) begin
          next_state = smc_pkg::ST_IDLE;
        end else begin
          cnt_next = cnt - 1'b1;
        end
      end
      default: begin
        next_state = smc_pkg::ST_IDLE;
        cnt_next   = '0;
      end
    endcase
  end

  //--------------------------------------------------------------------------
  // State registers
  //--------------------------------------------------------------------------
  always_ff @(posedge hclk or negedge rst_n) begin
    if (!rst_n) begin
      state <= smc_pkg::ST_IDLE;
      cnt   <= '0;
    end else begin
      state <= next_state;
      cnt   <= cnt_next;
    end
  end

  // Memory data is sampled at the edge that ends the strobe
  assign latch_data = (state == smc_pkg::ST_STROBE) && cnt_zero && !access_write;

endmodule

//--- smc_addr.sv
// Address generation for the external memory
// Address register and little-endian byte lane decode
// Byte enables and chip select from the current state

`timescale 1ns/10ps

module smc_addr (
  input  logic                          hclk,
  input  logic                          rst_n,
  input  logic                          new_access,
  input  logic [smc_pkg::ADDR_W-1:0]    haddr,
  input  logic [2:0]                    hsize,
  input  smc_pkg::smc_state_t           state,
  output logic [smc_pkg::ADDR_W-1:0]    smc_addr,
  output logic [smc_pkg::NUM_LANES-1:0] lane_en,
  output logic [smc_pkg::NUM_LANES-1:0] smc_n_be,
  output logic                          smc_n_cs
);

  logic [smc_pkg::NUM_LANES-1:0] lane_dec;   // Lanes of the bus transfer
  logic                          cs_active;  // Lead or strobe phase

  // Lane mask from size and low address bits
  always_comb begin
    case (hsize)
      smc_pkg::HSIZE_BYTE: lane_dec = 4'b0001 << haddr[1:0];
      smc_pkg::HSIZE_HALF: lane_dec = haddr[1] ? 4'b1100 : 4'b0011;
      default:             lane_dec = 4'b1111;   // Word and above
    endcase
  end

  always_ff @(posedge hclk) begin
    if (new_access) begin
      smc_addr <= haddr;
    end
  end

  always_ff @(posedge hclk or negedge rst_n) begin
    if (!rst_n) begin
      lane_en <= '0;
    end else if (new_access) begin
      lane_en <= lane_dec;
    end
  end

  // Select follows the state directly
  assign cs_active = (state == smc_pkg::ST_CSLE) || (state == smc_pkg::ST_STROBE);
  assign smc_n_cs  = !cs_active;
  assign smc_n_be  = cs_active ? ~lane_en : '1;   // Inactive outside the window

endmodule

//--- smc_strobe.sv
// Strobe generation for the external memory
// Read strobe, write enable and per-lane write strobes
// Write data output enable and busy flag
// All registered from the next state, so they switch with the state

`timescale 1ns/10ps

module smc_strobe (
  input  logic                          hclk,
  input  logic                          rst_n,
  input  smc_pkg::smc_state_t           next_state,
  input  logic                          access_write,
  input  logic [smc_pkg::NUM_LANES-1:0] lane_en,
  output logic                          smc_n_rd,
  output logic                          smc_n_wr,
  output logic [smc_pkg::NUM_LANES-1:0] smc_n_we,
  output logic                          smc_n_ext_oe,
  output logic                          smc_busy
);

  logic nxt_strobe;   // Next cycle is in the strobe phase
  logic nxt_cs;       // Next cycle has chip select active
  logic nxt_rd;
  logic nxt_wr;

  assign nxt_strobe = (next_state == smc_pkg::ST_STROBE);
  assign nxt_cs     = (next_state == smc_pkg::ST_CSLE) || nxt_strobe;
  assign nxt_rd     = nxt_strobe && !access_write;
  assign nxt_wr     = nxt_strobe && access_write;

  //--------------------------------------------------------------------------
  // Registered strobes, glitch free at the pins
  //--------------------------------------------------------------------------
  always_ff @(posedge hclk or negedge rst_n) begin
    if (!rst_n) begin
      smc_n_rd     <= 1'b1;
      smc_n_wr     <= 1'b1;
      smc_n_we     <= '1;
      smc_n_ext_oe <= 1'b1;
      smc_busy     <= 1'b0;
    end else begin
      smc_n_rd <= !nxt_rd;
      smc_n_wr <= !nxt_wr;
      // Only the lanes of the transfer get a write strobe
      smc_n_we <= nxt_wr ? ~lane_en : '1;
      // Drive write data for the whole chip select window
      smc_n_ext_oe <= !(nxt_cs && access_write);
      smc_busy     <= (next_state != smc_pkg::ST_IDLE);
    end
  end

endmodule

//--- smc_lite.sv
// Static memory controller top level
// AHB-Lite slave in, one 32-bit external memory bank out
// Sets the lead, wait and trail timing of the external cycle

`timescale 1ns/10ps

module smc_lite #(
  parameter int CSLE_CYCLES = 1,   // Lead cycles, at least 1
  parameter int WS_CYCLES   = 2,   // Wait states
  parameter int CSTE_CYCLES = 1    // Trail cycles, 0 skips the phase
) (
  input  logic                         hclk,
  input  logic                         rst_n,
  // AHB-Lite slave
  input  logic                         hsel,
  input  logic [smc_pkg::ADDR_W-1:0]   haddr,
  input  logic [1:0]                   htrans,
  input  logic                         hwrite,
  input  logic [2:0]                   hsize,
  input  logic [smc_pkg::DATA_W-1:0]   hwdata,
  input  logic                         hready,
  output logic [smc_pkg::DATA_W-1:0]   smc_hrdata,
  output logic                         smc_hready,
  output logic [1:0]                   smc_hresp,
  // External memory
  input  logic [smc_pkg::DATA_W-1:0]   data_smc,
  output logic [smc_pkg::ADDR_W-1:0]   smc_addr,
  output logic [smc_pkg::DATA_W-1:0]   smc_data,
  output logic [smc_pkg::NUM_LANES-1:0] smc_n_be,
  output logic                         smc_n_cs,
  output logic [smc_pkg::NUM_LANES-1:0] smc_n_we,
  output logic                         smc_n_wr,
  output logic                         smc_n_rd,
  output logic                         smc_n_ext_oe,
  output logic                         smc_busy
);

  logic                          new_access;    // Transfer accepted this cycle
  logic                          access_write;  // Direction of current access
  logic                          latch_data;    // Capture read data
  smc_pkg::smc_state_t           state;
  smc_pkg::smc_state_t           next_state;
  logic [smc_pkg::NUM_LANES-1:0] lane_en;       // Active byte lanes

  smc_ahb_if i_ahb_if (
    .hclk         (hclk),
    .rst_n        (rst_n),
    .hsel         (hsel),
    .htrans       (htrans),
    .hwrite       (hwrite),
    .hwdata       (hwdata),
    .hready       (hready),
    .data_smc     (data_smc),
    .state        (state),
    .latch_data   (latch_data),
    .new_access   (new_access),
    .access_write (access_write),
    .smc_data     (smc_data),
    .smc_hrdata   (smc_hrdata),
    .smc_hready   (smc_hready),
    .smc_hresp    (smc_hresp)
  );

  smc_state #(
    .CSLE_CYCLES (CSLE_CYCLES),
    .WS_CYCLES   (WS_CYCLES),
    .CSTE_CYCLES (CSTE_CYCLES)
  ) i_state (
    .hclk         (hclk),
    .rst_n        (rst_n),
    .new_access   (new_access),
    .access_write (access_write),
    .state        (state),
    .next_state   (next_state),
    .latch_data   (latch_data)
  );

  // Address and size go straight from the bus to the address block
  smc_addr i_addr (
    .hclk       (hclk),
    .rst_n      (rst_n),
    .new_access (new_access),
    .haddr      (haddr),
    .hsize      (hsize),
    .state      (state),
    .smc_addr   (smc_addr),
    .lane_en    (lane_en),
    .smc_n_be   (smc_n_be),
    .smc_n_cs   (smc_n_cs)
  );

  smc_strobe i_strobe (
    .hclk         (hclk),
    .rst_n        (rst_n),
    .next_state   (next_state),
    .access_write (access_write),
    .lane_en      (lane_en),
    .smc_n_rd     (smc_n_rd),
    .smc_n_wr     (smc_n_wr),
    .smc_n_we     (smc_n_we),
    .smc_n_ext_oe (smc_n_ext_oe),
    .smc_busy     (smc_busy)
  );

endmodule

//--- tb_smc_tasks.svh
// Testbench tasks for the static memory controller
// Fill pattern, lane rule and value check
// AHB transfer driver with per-cycle pin checks
// Directed tests

function automatic logic [31:0] fill_word(input logic [7:0] idx);
  return {idx, ~idx, idx ^ 8'h3c, idx + 8'h11};   // Every index bit matters
endfunction

// Little-endian lanes touched by a transfer
function automatic logic [3:0] lane_mask(input logic [2:0] size, input logic [1:0] off);
  logic [3:0] m;
  for (int l = 0; l < 4; l++) begin
    case (size)
      smc_pkg::HSIZE_BYTE: m[l] = (l == off);          // Only the addressed byte
      smc_pkg::HSIZE_HALF: m[l] = (l[1] == off[1]);    // Lower or upper half
      default:             m[l] = 1'b1;
    endcase
  end
  return m;
endfunction

task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
  if (got !== exp) begin
    $display("[FAIL] t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
    $display("Simulation FAILED");
    $fatal(1, "value mismatch");
  end
endtask

//----------------------------------------------------------------------------
// One AHB transfer, entered and left 1 ns after a rising edge in idle
//----------------------------------------------------------------------------
task automatic ahb_access(input logic wr, input logic [31:0] addr, input logic [2:0] size,
                          input logic [31:0] wdata);
  logic [3:0] lanes;
  logic [3:0] lanes_n;   // Active low lane pattern
  logic [7:0] idx;
  logic       exp_cs;
  logic       exp_stb;
  int         k;
  lanes   = lane_mask(size, addr[1:0]);
  lanes_n = ~lanes;
  idx     = addr[9:2];
  k       = 0;
  hsel   = 1'b1;   // Address phase
  haddr  = addr;
  htrans = smc_pkg::HTRANS_NONSEQ;
  hwrite = wr;
  hsize  = size;
  @(posedge hclk);
  #1;
  hsel   = 1'b0;
  htrans = smc_pkg::HTRANS_IDLE;
  hwdata = wdata;  // First data phase cycle
  while (!smc_hready) begin
    exp_cs  = (k < CSLE + WS + 1);
    exp_stb = exp_cs && (k >= CSLE);   // Last WS+1 cycles of the select window
    check_val("smc_n_cs", 32'(smc_n_cs), 32'(!exp_cs));
    check_val("smc_n_be", 32'(smc_n_be), 32'(exp_cs ? lanes_n : 4'hf));
    check_val("smc_n_rd", 32'(smc_n_rd), 32'(!(exp_stb && !wr)));
    check_val("smc_n_wr", 32'(smc_n_wr), 32'(!(exp_stb && wr)));
    check_val("smc_n_we", 32'(smc_n_we), 32'((exp_stb && wr) ? lanes_n : 4'hf));
    check_val("smc_n_ext_oe", 32'(smc_n_ext_oe), 32'(!(exp_cs && wr)));
    check_val("smc_busy", 32'(smc_busy), 32'(1));
    check_val("smc_hresp", 32'(smc_hresp), 32'(smc_pkg::HRESP_OKAY));
    check_val("smc_addr", smc_addr, addr);
    if (exp_stb && wr) begin
      check_val("smc_data", smc_data, wdata);   // Held from the first strobe cycle
    end
    k++;
    @(posedge hclk);
    #1;
  end
  check_val("smc_hready low cycles", k, CSLE + WS + 1 + CSTE);
  if (wr) begin
    for (int l = 0; l < 4; l++) begin
      if (lanes[l]) shadow[idx][8*l +: 8] = wdata[8*l +: 8];
    end
  end else begin
    check_val("smc_hrdata", smc_hrdata, shadow[idx]);
  end
endtask

//----------------------------------------------------------------------------
// Directed tests
//----------------------------------------------------------------------------
task automatic reset_values();
  check_val("smc_hready", 32'(smc_hready), 32'(1));
  check_val("smc_busy", 32'(smc_busy), 32'(0));
  check_val("smc_n_cs", 32'(smc_n_cs), 32'(1));
  check_val("smc_n_be", 32'(smc_n_be), 32'(4'hf));
  check_val("smc_n_rd", 32'(smc_n_rd), 32'(1));
  check_val("smc_n_wr", 32'(smc_n_wr), 32'(1));
  check_val("smc_n_we", 32'(smc_n_we), 32'(4'hf));
  check_val("smc_n_ext_oe", 32'(smc_n_ext_oe), 32'(1));
  check_val("smc_hresp", 32'(smc_hresp), 32'(smc_pkg::HRESP_OKAY));
endtask

task automatic word_write_read();
  ahb_access(1'b1, 32'h40, smc_pkg::HSIZE_WORD, $urandom());
  ahb_access(1'b0, 32'h40, smc_pkg::HSIZE_WORD, 32'h0);
endtask

// Each write followed by a word read of the whole location
task automatic sub_word_writes();
  for (int off = 0; off < 4; off++) begin
    ahb_access(1'b1, 32'h80 + 32'(off), smc_pkg::HSIZE_BYTE, $urandom());
    ahb_access(1'b0, 32'h80, smc_pkg::HSIZE_WORD, 32'h0);
  end
  for (int off = 0; off < 4; off += 2) begin
    ahb_access(1'b1, 32'hc0 + 32'(off), smc_pkg::HSIZE_HALF, $urandom());
    ahb_access(1'b0, 32'hc0, smc_pkg::HSIZE_WORD, 32'h0);
  end
endtask

// hsel low, IDLE, BUSY, then hready low
task automatic ignored_transfers();
  for (int c = 0; c < 4; c++) begin
    hsel   = (c != 0);
    haddr  = 32'h100;
    hwrite = 1'b1;
    hsize  = smc_pkg::HSIZE_WORD;
    htrans = (c == 1) ? smc_pkg::HTRANS_IDLE :
             (c == 2) ? smc_pkg::HTRANS_BUSY : smc_pkg::HTRANS_NONSEQ;
    hready = (c != 3);
    repeat (4) begin
      @(posedge hclk);
      #1;
      check_val("smc_n_cs", 32'(smc_n_cs), 32'(1));
      check_val("smc_busy", 32'(smc_busy), 32'(0));
    end
  end
  hsel   = 1'b0;
  htrans = smc_pkg::HTRANS_IDLE;
  hready = 1'b1;
endtask

task automatic random_back_to_back();
  logic        wr;
  logic [2:0]  size;
  logic [31:0] addr;
  for (int n = 0; n < 30; n++) begin
    wr   = 1'($urandom_range(0, 1));
    size = 3'($urandom_range(0, 2));
    addr = 32'($urandom_range(0, 63));   // Small window so reads hit earlier writes
    addr = addr & ~((32'd1 << size) - 32'd1);   // Aligned to the size
    ahb_access(wr, addr, size, $urandom());
  end
endtask

//--- tb_smc_lite.sv
// Testbench top for the static memory controller
// Clock, reset, 256-word memory model and cycle timeout
// Directed test sequence built from the included tasks

`timescale 1ns/10ps

module tb_smc_lite;

  localparam int CSLE         = 1;   // Lead cycles
  localparam int WS           = 2;   // Wait states
  localparam int CSTE         = 1;   // Trail cycles
  localparam int RESET_CYCLES = 8;
  localparam int NUM_ACCESSES = 44;  // 2 word, 12 sub-word, 30 random
  // Busy cycles plus one idle cycle per access, ignored transfers sit in the margin
  localparam int TIMEOUT_CYCLES = NUM_ACCESSES * (CSLE + WS + CSTE + 2) + RESET_CYCLES + 100;

  logic        hclk = 1'b0;
  logic        rst_n;
  logic        hsel;
  logic [31:0] haddr;
  logic [1:0]  htrans;
  logic        hwrite;
  logic [2:0]  hsize;
  logic [31:0] hwdata;
  logic        hready;
  logic [31:0] smc_hrdata;
  logic        smc_hready;
  logic [1:0]  smc_hresp;
  logic [31:0] data_smc;
  logic [31:0] smc_addr;
  logic [31:0] smc_data;
  logic [3:0]  smc_n_be;
  logic        smc_n_cs;
  logic [3:0]  smc_n_we;
  logic        smc_n_wr;
  logic        smc_n_rd;
  logic        smc_n_ext_oe;
  logic        smc_busy;

  logic [31:0] mem [0:255];      // External memory bank
  logic [31:0] shadow [0:255];   // Expected contents
  int          cycles = 0;
  int unsigned seed;

  `include "tb_smc_tasks.svh"

  smc_lite #(
    .CSLE_CYCLES (CSLE),
    .WS_CYCLES   (WS),
    .CSTE_CYCLES (CSTE)
  ) UUT (
    .hclk (hclk), .rst_n (rst_n), .hsel (hsel), .haddr (haddr), .htrans (htrans),
    .hwrite (hwrite), .hsize (hsize), .hwdata (hwdata), .hready (hready),
    .smc_hrdata (smc_hrdata), .smc_hready (smc_hready), .smc_hresp (smc_hresp),
    .data_smc (data_smc), .smc_addr (smc_addr), .smc_data (smc_data),
    .smc_n_be (smc_n_be), .smc_n_cs (smc_n_cs), .smc_n_we (smc_n_we),
    .smc_n_wr (smc_n_wr), .smc_n_rd (smc_n_rd), .smc_n_ext_oe (smc_n_ext_oe),
    .smc_busy (smc_busy)
  );

  always #2 hclk = ~hclk;   // 4 ns period

  //--------------------------------------------------------------------------
  // Memory model
  //--------------------------------------------------------------------------
  assign data_smc = mem[smc_addr[9:2]];   // Asynchronous read

  // Write lanes sampled mid-cycle, away from the strobe edges
  always @(negedge hclk) begin
    if (!rst_n) begin
      for (int i = 0; i < 256; i++) begin
        mem[i] <= fill_word(8'(i));
      end
    end else if (!smc_n_wr) begin
      for (int l = 0; l < 4; l++) begin
        if (!smc_n_we[l]) begin
          mem[smc_addr[9:2]][8*l +: 8] <= smc_data[8*l +: 8];
        end
      end
    end
  end

  // Run limit
  always @(posedge hclk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: test sequence still running after %0d cycles", cycles);
      $display("Simulation FAILED");
      $fatal(1, "timeout");
    end
  end

  //--------------------------------------------------------------------------
  // Test sequence
  //--------------------------------------------------------------------------
  initial begin
    seed   = $urandom(97955);
    rst_n  = 1'b0;
    hsel   = 1'b0;
    haddr  = 32'h0;
    htrans = smc_pkg::HTRANS_IDLE;
    hwrite = 1'b0;
    hsize  = smc_pkg::HSIZE_WORD;
    hwdata = 32'h0;
    hready = 1'b1;
    for (int i = 0; i < 256; i++) begin
      shadow[i] = fill_word(8'(i));
    end
    repeat (RESET_CYCLES) @(posedge hclk);
    #1 rst_n = 1'b1;

    reset_values();
    word_write_read();
    sub_word_writes();
    ignored_transfers();
    random_back_to_back();

    $display("Simulation PASSED");
    $finish;
  end

endmodule

//--- all.f
+incdir+.
smc_pkg.sv
smc_ahb_if.sv
smc_state.sv
smc_addr.sv
smc_strobe.sv
smc_lite.sv
tb_smc_lite.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the memory controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module tb_smc_lite -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/Vtb_smc_lite
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation run failed with status $status"
  exit 1
fi
exit 0
